// ==== board_pins_pkg.sv ====
package board_pins_pkg;

  // header size and peripheral counts
  localparam int NUM_PINS = 31;
  localparam int NUM_UART = 4;   // mode-2 bank
  localparam int NUM_I2C  = 3;   // mode-2 bank
  localparam int NUM_SPI  = 3;   // mode-3 bank

  // first pin of each alternate-function block
  localparam int UART_BASE_PIN = 1;   // tx on base+2k, rx on base+2k+1
  localparam int I2C_BASE_PIN  = 9;   // scl on base+2j, sda on base+2j+1
  localparam int SPI_BASE_PIN  = 3;   // mosi, sck, cs_n, miso every 4 pins
  localparam int I2C3_SCL_PIN  = 1;   // fourth I2C sits in the SPI bank
  localparam int I2C3_SDA_PIN  = 2;

  typedef enum logic [1:0] {
    MODE_GPIO = 2'd0,
    MODE_PWM  = 2'd1,
    MODE_ALT2 = 2'd2,   // uart and i2c bank
    MODE_ALT3 = 2'd3    // spi and i2c3 bank
  } pin_mode_e;

  typedef logic [NUM_PINS-1:0] pin_vec_t;

  typedef struct packed {
    logic [NUM_UART-1:0] uart_tx;
    logic [NUM_I2C-1:0]  scl_o;
    logic [NUM_I2C-1:0]  sda_o;
    logic [NUM_I2C-1:0]  scl_en;   // active high drive enable
    logic [NUM_I2C-1:0]  sda_en;
  } alt2_out_t;

  typedef struct packed {
    logic [NUM_UART-1:0] uart_rx;
    logic [NUM_I2C-1:0]  scl_i;
    logic [NUM_I2C-1:0]  sda_i;
  } alt2_in_t;

  typedef struct packed {
    logic [NUM_SPI-1:0] mosi;
    logic [NUM_SPI-1:0] sck;
    logic [NUM_SPI-1:0] cs_n;
    logic               i2c3_scl_o;
    logic               i2c3_sda_o;
    logic               i2c3_scl_en;
    logic               i2c3_sda_en;
  } alt3_out_t;

  typedef struct packed {
    logic [NUM_SPI-1:0] miso;
    logic               i2c3_scl_i;
    logic               i2c3_sda_i;
  } alt3_in_t;

  // plain spi flash master
  typedef struct packed {
    logic sck;
    logic cs_n;
    logic mosi;
  } spi_flash_t;

  // qspi master with one dataoe bit per io line
  typedef struct packed {
    logic       dclk;
    logic       ncs;
    logic       oe_n;
    logic [3:0] dataout;
    logic [3:0] dataoe;
  } qspi_t;

endpackage

// ==== pio_cfg_pkg.sv ====
package pio_cfg_pkg;

  // cycles the reset is held after the synchronizer releases
  localparam int RESET_STRETCH = 32;

  localparam int PIN_IDX_W = 5;   // enough for 31 pins

  // top bit of every configuration word
  typedef enum logic {
    CFG_MODE = 1'b0,
    CFG_GPIO = 1'b1
  } cfg_kind_e;

  // sets the 2-bit mode of one pin
  typedef struct packed {
    cfg_kind_e                 kind;
    logic [PIN_IDX_W-1:0]      pin;
    board_pins_pkg::pin_mode_e mode;
    logic [7:0]                pad;
  } cfg_mode_cmd_t;

  // sets direction and output level of one pin
  typedef struct packed {
    cfg_kind_e            kind;
    logic [PIN_IDX_W-1:0] pin;
    logic                 dir;   // 1 drives the pin
    logic                 out;
    logic [7:0]           pad;
  } cfg_gpio_cmd_t;

  // one 16-bit host word read as either command
  typedef union packed {
    cfg_mode_cmd_t mode_cmd;
    cfg_gpio_cmd_t gpio_cmd;
  } cfg_word_u;

endpackage

// ==== reset_stretch.sv ====
`timescale 1ns/1ps

module reset_stretch
(
  input  logic wMEM_CLK,
  input  logic arst_n_i,
  output logic sys_rst_n_o
);

  import pio_cfg_pkg::*;

  localparam int CNT_W = $clog2(RESET_STRETCH + 1);

  logic [1:0]       sync_q;   // two-stage release synchronizer
  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge wMEM_CLK or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sync_q <= '0;
      cnt_q  <= '0;
    end
    else
    begin
      sync_q <= {sync_q[0], 1'b1};
      if (sync_q[1] && (cnt_q != CNT_W'(RESET_STRETCH)))
        cnt_q <= cnt_q + 1'b1;   // saturates at the stretch length
    end
  end

  assign sys_rst_n_o = (cnt_q == CNT_W'(RESET_STRETCH));

endmodule

// ==== pio_cfg_regs.sv ====
`timescale 1ns/1ps

module pio_cfg_regs
(
  input  logic                      wMEM_CLK,
  input  logic                      arst_n_i,
  input  logic                      sys_rst_n_i,
  input  logic                      cfg_req_i,
  input  pio_cfg_pkg::cfg_word_u    cfg_word_i,
  output logic                      cfg_ack_o,
  output board_pins_pkg::pin_mode_e pin_mode_o [board_pins_pkg::NUM_PINS],
  output board_pins_pkg::pin_vec_t  pin_dir_o,
  output board_pins_pkg::pin_vec_t  gpio_out_o
);

  import board_pins_pkg::*;
  import pio_cfg_pkg::*;

  logic      ack_q;
  pin_mode_e mode_q [NUM_PINS];
  pin_vec_t  dir_q;
  pin_vec_t  out_q;
  logic      idx_ok;
  logic      take;

  // pin field sits at the same place in both commands
  assign idx_ok = (int'(cfg_word_i.mode_cmd.pin) < NUM_PINS);

  assign take = cfg_req_i && !ack_q;   // new request not yet acked

  always_ff @(posedge wMEM_CLK or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q  <= 1'b0;
      mode_q <= '{default: MODE_GPIO};
      dir_q  <= '0;
      out_q  <= '0;
    end
    else if (!sys_rst_n_i)
    begin
      // held in reset until the stretched reset releases
      ack_q  <= 1'b0;
      mode_q <= '{default: MODE_GPIO};
      dir_q  <= '0;
      out_q  <= '0;
    end
    else if (take)
    begin
      ack_q <= 1'b1;
      if (idx_ok)   // out of range index is acked and dropped
      begin
        if (cfg_word_i.mode_cmd.kind == CFG_MODE)
        begin
          mode_q[cfg_word_i.mode_cmd.pin] <= cfg_word_i.mode_cmd.mode;
        end
        else
        begin
          dir_q[cfg_word_i.gpio_cmd.pin] <= cfg_word_i.gpio_cmd.dir;
          out_q[cfg_word_i.gpio_cmd.pin] <= cfg_word_i.gpio_cmd.out;
        end
      end
    end
    else if (!cfg_req_i && ack_q)
    begin
      ack_q <= 1'b0;   // phase 4 once the host drops req
    end
  end

  assign cfg_ack_o  = ack_q;
  assign pin_mode_o = mode_q;
  assign pin_dir_o  = dir_q;
  assign gpio_out_o = out_q;

endmodule

// ==== header_pin_mux.sv ====
`timescale 1ns/1ps

module header_pin_mux
(
  input  board_pins_pkg::pin_mode_e pin_mode_i [board_pins_pkg::NUM_PINS],
  input  board_pins_pkg::pin_vec_t  pin_dir_i,
  input  board_pins_pkg::pin_vec_t  gpio_out_i,
  input  board_pins_pkg::pin_vec_t  pwm_i,
  input  board_pins_pkg::alt2_out_t alt2_out_i,
  input  board_pins_pkg::alt3_out_t alt3_out_i,
  input  board_pins_pkg::pin_vec_t  pin_in_i,
  output board_pins_pkg::pin_vec_t  pin_out_o,
  output board_pins_pkg::pin_vec_t  pin_oe_o,
  output board_pins_pkg::alt2_in_t  alt2_in_o,
  output board_pins_pkg::alt3_in_t  alt3_in_o
);

  import board_pins_pkg::*;

  pin_vec_t a2_out;   // bank maps spread over the header
  pin_vec_t a2_oe;
  pin_vec_t a3_out;
  pin_vec_t a3_oe;

  // mode-2 bank of uart and i2c
  always_comb
  begin
    a2_out = '0;
    a2_oe  = '0;
    for (int k = 0; k < NUM_UART; k++)
    begin
      a2_out[UART_BASE_PIN + 2*k] = alt2_out_i.uart_tx[k];
      a2_oe[UART_BASE_PIN + 2*k]  = 1'b1;   // rx pin stays released
    end
    for (int j = 0; j < NUM_I2C; j++)
    begin
      a2_out[I2C_BASE_PIN + 2*j]     = alt2_out_i.scl_o[j];
      a2_oe[I2C_BASE_PIN + 2*j]      = alt2_out_i.scl_en[j];
      a2_out[I2C_BASE_PIN + 2*j + 1] = alt2_out_i.sda_o[j];
      a2_oe[I2C_BASE_PIN + 2*j + 1]  = alt2_out_i.sda_en[j];
    end
  end

  // mode-3 bank of spi and i2c3
  always_comb
  begin
    a3_out = '0;
    a3_oe  = '0;
    for (int j = 0; j < NUM_SPI; j++)
    begin
      a3_out[SPI_BASE_PIN + 4*j]     = alt3_out_i.mosi[j];
      a3_out[SPI_BASE_PIN + 4*j + 1] = alt3_out_i.sck[j];
      a3_out[SPI_BASE_PIN + 4*j + 2] = alt3_out_i.cs_n[j];
      a3_oe[SPI_BASE_PIN + 4*j]      = 1'b1;
      a3_oe[SPI_BASE_PIN + 4*j + 1]  = 1'b1;
      a3_oe[SPI_BASE_PIN + 4*j + 2]  = 1'b1;   // miso at +3 never driven
    end
    a3_out[I2C3_SCL_PIN] = alt3_out_i.i2c3_scl_o;
    a3_oe[I2C3_SCL_PIN]  = alt3_out_i.i2c3_scl_en;
    a3_out[I2C3_SDA_PIN] = alt3_out_i.i2c3_sda_o;
    a3_oe[I2C3_SDA_PIN]  = alt3_out_i.i2c3_sda_en;
  end

  // per-pin selection with the enable of each pin
  always_comb
  begin
    for (int i = 0; i < NUM_PINS; i++)
    begin
      case (pin_mode_i[i])
        MODE_GPIO:
        begin
          pin_out_o[i] = gpio_out_i[i];
          pin_oe_o[i]  = pin_dir_i[i];
        end
        MODE_PWM:
        begin
          pin_out_o[i] = pwm_i[i];
          pin_oe_o[i]  = 1'b1;
        end
        MODE_ALT2:
        begin
          pin_out_o[i] = a2_out[i];
          pin_oe_o[i]  = a2_oe[i];
        end
        default:
        begin
          pin_out_o[i] = a3_out[i];
          pin_oe_o[i]  = a3_oe[i];
        end
      endcase
    end
  end

  // inputs are routed back whatever the mode
  always_comb
  begin
    for (int k = 0; k < NUM_UART; k++)
      alt2_in_o.uart_rx[k] = pin_in_i[UART_BASE_PIN + 2*k + 1];
    for (int j = 0; j < NUM_I2C; j++)
    begin
      alt2_in_o.scl_i[j] = pin_in_i[I2C_BASE_PIN + 2*j];
      alt2_in_o.sda_i[j] = pin_in_i[I2C_BASE_PIN + 2*j + 1];
    end
    for (int j = 0; j < NUM_SPI; j++)
      alt3_in_o.miso[j] = pin_in_i[SPI_BASE_PIN + 4*j + 3];
    alt3_in_o.i2c3_scl_i = pin_in_i[I2C3_SCL_PIN];
    alt3_in_o.i2c3_sda_i = pin_in_i[I2C3_SDA_PIN];
  end

endmodule

// ==== flash_pin_share.sv ====
`timescale 1ns/1ps

module flash_pin_share
(
  input  board_pins_pkg::spi_flash_t spi_flash_i,
  input  board_pins_pkg::qspi_t      qspi_i,
  input  logic [3:0]                 flash_io_i,
  output logic                       flash_sck_o,
  output logic                       flash_cs_n_o,
  output logic [3:0]                 flash_io_o,
  output logic [3:0]                 flash_io_oe_o,
  output logic [3:0]                 qspi_datain_o,
  output logic                       spi_miso_o
);

  logic       qspi_act;
  logic       spi_sel;
  logic [3:0] spi_out;
  logic [3:0] spi_oe;

  assign qspi_act = !qspi_i.ncs && !qspi_i.oe_n;
  assign spi_sel  = !spi_flash_i.cs_n;

  assign flash_cs_n_o = qspi_i.ncs & spi_flash_i.cs_n;   // either master selects

  // spi clock wins while its chip select is low
  assign flash_sck_o = spi_sel  ? spi_flash_i.sck :
                       qspi_act ? qspi_i.dclk     : 1'b0;

  // spi drives mosi on io0, holds wp and hold high, leaves io1 as miso
  assign spi_out = {1'b1, 1'b1, 1'b0, spi_flash_i.mosi};
  assign spi_oe  = {spi_sel, spi_sel, 1'b0, spi_sel};

  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      if (qspi_act && qspi_i.dataoe[k])
      begin
        flash_io_o[k]    = qspi_i.dataout[k];
        flash_io_oe_o[k] = 1'b1;
      end
      else
      begin
        flash_io_o[k]    = spi_out[k];
        flash_io_oe_o[k] = spi_oe[k];
      end
    end
  end

  assign qspi_datain_o = flash_io_i;
  assign spi_miso_o    = flash_io_i[1];

endmodule

// ==== pio_bridge_top.sv ====
`timescale 1ns/1ps

module pio_bridge_top
(
  input  logic                       wMEM_CLK,
  input  logic                       arst_n_i,
  input  logic                       cfg_req_i,
  input  pio_cfg_pkg::cfg_word_u     cfg_word_i,
  output logic                       cfg_ack_o,
  input  board_pins_pkg::pin_vec_t   pwm_i,
  input  board_pins_pkg::alt2_out_t  alt2_out_i,
  input  board_pins_pkg::alt3_out_t  alt3_out_i,
  input  board_pins_pkg::pin_vec_t   pin_in_i,
  output board_pins_pkg::pin_vec_t   pin_out_o,
  output board_pins_pkg::pin_vec_t   pin_oe_o,
  output board_pins_pkg::alt2_in_t   alt2_in_o,
  output board_pins_pkg::alt3_in_t   alt3_in_o,
  input  board_pins_pkg::spi_flash_t spi_flash_i,
  input  board_pins_pkg::qspi_t      qspi_i,
  input  logic [3:0]                 flash_io_i,
  output logic                       flash_sck_o,
  output logic                       flash_cs_n_o,
  output logic [3:0]                 flash_io_o,
  output logic [3:0]                 flash_io_oe_o,
  output logic [3:0]                 qspi_datain_o,
  output logic                       spi_miso_o
);

  import board_pins_pkg::*;

  logic      sys_rst_n;
  pin_mode_e pin_mode [NUM_PINS];
  pin_vec_t  pin_dir;
  pin_vec_t  gpio_out;

  reset_stretch u_reset_stretch (
    .wMEM_CLK    (wMEM_CLK),
    .arst_n_i    (arst_n_i),
    .sys_rst_n_o (sys_rst_n)
  );

  pio_cfg_regs u_pio_cfg_regs (
    .wMEM_CLK    (wMEM_CLK),
    .arst_n_i    (arst_n_i),
    .sys_rst_n_i (sys_rst_n),
    .cfg_req_i   (cfg_req_i),
    .cfg_word_i  (cfg_word_i),
    .cfg_ack_o   (cfg_ack_o),
    .pin_mode_o  (pin_mode),
    .pin_dir_o   (pin_dir),
    .gpio_out_o  (gpio_out)
  );

  header_pin_mux u_header_pin_mux (
    .pin_mode_i (pin_mode),
    .pin_dir_i  (pin_dir),
    .gpio_out_i (gpio_out),
    .pwm_i      (pwm_i),
    .alt2_out_i (alt2_out_i),
    .alt3_out_i (alt3_out_i),
    .pin_in_i   (pin_in_i),
    .pin_out_o  (pin_out_o),
    .pin_oe_o   (pin_oe_o),
    .alt2_in_o  (alt2_in_o),
    .alt3_in_o  (alt3_in_o)
  );

  flash_pin_share u_flash_pin_share (
    .spi_flash_i   (spi_flash_i),
    .qspi_i        (qspi_i),
    .flash_io_i    (flash_io_i),
    .flash_sck_o   (flash_sck_o),
    .flash_cs_n_o  (flash_cs_n_o),
    .flash_io_o    (flash_io_o),
    .flash_io_oe_o (flash_io_oe_o),
    .qspi_datain_o (qspi_datain_o),
    .spi_miso_o    (spi_miso_o)
  );

endmodule

// ==== pio_bridge_properties.sv ====
`timescale 1ns/1ps

module pio_bridge_properties
(
  input logic wMEM_CLK,
  input logic arst_n_i,
  input logic sys_rst_n_i,
  input logic cfg_req_i,
  input logic cfg_ack_i
);

  // ack only answers a request seen on the edge before
  ack_needs_req: assert property (@(posedge wMEM_CLK) disable iff (!arst_n_i)
    $rose(cfg_ack_i) |-> $past(cfg_req_i))
    else $error("ack rose without a pending request");

  ack_holds: assert property (@(posedge wMEM_CLK) disable iff (!sys_rst_n_i)
    (cfg_ack_i && cfg_req_i) |=> cfg_ack_i)
    else $error("ack dropped while the request was still high");

  no_ack_in_reset: assert property (@(posedge wMEM_CLK)
    !sys_rst_n_i |-> !cfg_ack_i)
    else $error("ack high while the stretched reset is active");

endmodule

bind pio_cfg_regs pio_bridge_properties u_cfg_props (
  .wMEM_CLK    (wMEM_CLK),
  .arst_n_i    (arst_n_i),
  .sys_rst_n_i (sys_rst_n_i),
  .cfg_req_i   (cfg_req_i),
  .cfg_ack_i   (cfg_ack_o)
);

// ==== tb_pio_bridge_top.sv ====
`timescale 1ns/1ps

module tb_pio_bridge_top;

  import board_pins_pkg::*;
  import pio_cfg_pkg::*;

  localparam int CYCLE_LIMIT = 400 * 6 + 2000;

  logic        wMEM_CLK;
  logic        arst_n;
  logic        cfg_req;
  cfg_word_u   cfg_word;
  logic        cfg_ack;
  pin_vec_t    pwm;
  pin_vec_t    pin_in;
  pin_vec_t    pin_out;
  pin_vec_t    pin_oe;
  alt2_out_t   alt2_out;
  alt3_out_t   alt3_out;
  alt2_in_t    alt2_in;
  alt3_in_t    alt3_in;
  spi_flash_t  spi_flash;
  qspi_t       qspi;
  logic [3:0]  flash_io;
  logic        flash_sck;
  logic        flash_cs_n;
  logic [3:0]  flash_io_out;
  logic [3:0]  flash_io_oe;
  logic [3:0]  qspi_datain;
  logic        spi_miso;
  logic [31:0] lcg_state;
  int          cycles;
  int          checks;
  int          mismatches;
  logic [1:0]  m_mode [NUM_PINS];   // reference register copy
  pin_vec_t    m_dir;
  pin_vec_t    m_out;

  pio_bridge_top uut (
    .wMEM_CLK (wMEM_CLK), .arst_n_i (arst_n), .cfg_req_i (cfg_req),
    .cfg_word_i (cfg_word), .cfg_ack_o (cfg_ack), .pwm_i (pwm),
    .alt2_out_i (alt2_out), .alt3_out_i (alt3_out), .pin_in_i (pin_in),
    .pin_out_o (pin_out), .pin_oe_o (pin_oe), .alt2_in_o (alt2_in),
    .alt3_in_o (alt3_in), .spi_flash_i (spi_flash), .qspi_i (qspi),
    .flash_io_i (flash_io), .flash_sck_o (flash_sck), .flash_cs_n_o (flash_cs_n),
    .flash_io_o (flash_io_out), .flash_io_oe_o (flash_io_oe),
    .qspi_datain_o (qspi_datain), .spi_miso_o (spi_miso)
  );

  always #2 wMEM_CLK = ~wMEM_CLK;

  always @(posedge wMEM_CLK)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper halves of two lcg steps
  function automatic logic [31:0] rand_word();
    logic [31:0] a;
    logic [31:0] b;
    a = lcg_next();
    b = lcg_next();
    return {a[31:16], b[31:16]};
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      mismatches++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // {oe, out} of one header pin from the pin map
  function automatic logic [1:0] pin_expect(input int p);
    int         j;
    logic [1:0] res;
    res = 2'b00;   // released
    j = 0;
    case (m_mode[p])
      2'd0:
        res = {m_dir[p], m_out[p]};
      2'd1:
        res = {1'b1, pwm[p]};
      2'd2:
      begin
        if (p >= 1 && p <= 8 && p % 2 == 1)
          res = {1'b1, alt2_out.uart_tx[(p - 1) / 2]};
        else if (p >= 9 && p <= 14)
        begin
          j = (p - 9) / 2;
          res = (p % 2 == 1) ? {alt2_out.scl_en[j], alt2_out.scl_o[j]} :
                               {alt2_out.sda_en[j], alt2_out.sda_o[j]};
        end
      end
      default:
      begin
        j = (p - 3) / 4;
        if (p == 1)
          res = {alt3_out.i2c3_scl_en, alt3_out.i2c3_scl_o};
        else if (p == 2)
          res = {alt3_out.i2c3_sda_en, alt3_out.i2c3_sda_o};
        else if (p >= 3 && p <= 14 && (p - 3) % 4 == 0)
          res = {1'b1, alt3_out.mosi[j]};
        else if (p >= 3 && p <= 14 && (p - 3) % 4 == 1)
          res = {1'b1, alt3_out.sck[j]};
        else if (p >= 3 && p <= 14 && (p - 3) % 4 == 2)
          res = {1'b1, alt3_out.cs_n[j]};
      end
    endcase
    return res;
  endfunction

  task automatic check_all();
    pin_vec_t   e_out;
    pin_vec_t   e_oe;
    pin_vec_t   care;
    logic [1:0] pe;
    alt2_in_t   e2;
    alt3_in_t   e3;
    logic       q_act;
    logic [3:0] f_out;
    logic [3:0] f_oe;
    for (int p = 0; p < NUM_PINS; p++)
    begin
      pe = pin_expect(p);
      {e_oe[p], e_out[p]} = pe;
      care[p] = pe[1] || (m_mode[p] == 2'd0);   // released bank pins carry no level
    end
    compare_value("pin_oe", 32'(pin_oe), 32'(e_oe));
    compare_value("pin_out", 32'(pin_out & care), 32'(e_out & care));
    e2.uart_rx = {pin_in[8], pin_in[6], pin_in[4], pin_in[2]};
    e2.scl_i   = {pin_in[13], pin_in[11], pin_in[9]};
    e2.sda_i   = {pin_in[14], pin_in[12], pin_in[10]};
    e3.miso    = {pin_in[14], pin_in[10], pin_in[6]};
    e3.i2c3_scl_i = pin_in[1];
    e3.i2c3_sda_i = pin_in[2];
    compare_value("alt2_in", 32'(alt2_in), 32'(e2));
    compare_value("alt3_in", 32'(alt3_in), 32'(e3));
    q_act = !qspi.ncs && !qspi.oe_n;
    for (int k = 0; k < 4; k++)
    begin
      f_oe[k]  = (q_act && qspi.dataoe[k]) || (!spi_flash.cs_n && k != 1);
      f_out[k] = (q_act && qspi.dataoe[k]) ? qspi.dataout[k] :
                 (k == 0) ? spi_flash.mosi : f_oe[k];
    end
    compare_value("flash_io_oe", 32'(flash_io_oe), 32'(f_oe));
    compare_value("flash_io", 32'(flash_io_out & f_oe), 32'(f_out & f_oe));
    compare_value("flash sck/cs_n/miso", 32'({flash_sck, flash_cs_n, spi_miso}),
                  32'({!spi_flash.cs_n ? spi_flash.sck : (q_act && qspi.dclk),
                       !(!qspi.ncs || !spi_flash.cs_n), flash_io[1]}));
    compare_value("qspi_datain", 32'(qspi_datain), 32'(flash_io));
  endtask

  task automatic drive_random_inputs();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    r1 = rand_word();
    r2 = rand_word();
    r3 = rand_word();
    pwm       <= r1[30:0];
    pin_in    <= r2[30:0];
    alt2_out  <= r3[15:0];
    alt3_out  <= r3[28:16];
    r1 = rand_word();
    spi_flash <= r1[2:0];
    qspi      <= r1[13:3];
    flash_io  <= r1[17:14];
  endtask

  // four-phase write as seen from the host
  task automatic host_write(input cfg_word_u w);
    @(posedge wMEM_CLK);
    cfg_word <= w;
    cfg_req  <= 1'b1;
    @(negedge wMEM_CLK);
    while (!cfg_ack)
      @(negedge wMEM_CLK);
    @(posedge wMEM_CLK);
    cfg_req <= 1'b0;
    @(negedge wMEM_CLK);
    while (cfg_ack)
      @(negedge wMEM_CLK);
  endtask

  task automatic random_write(input logic gpio_only, input logic force_oob);
    logic [31:0] r;
    logic [4:0]  pin;
    logic        is_gpio;
    cfg_word_u   w;
    r = rand_word();
    pin = force_oob ? 5'd31 : r[20:16];
    is_gpio = gpio_only || r[31];
    w = cfg_word_u'(r[15:0]);   // random pad bits
    if (is_gpio)
    begin
      w.gpio_cmd.kind = CFG_GPIO;
      w.gpio_cmd.pin  = pin;
      w.gpio_cmd.dir  = r[21];
      w.gpio_cmd.out  = r[22];
    end
    else
    begin
      w.mode_cmd.kind = CFG_MODE;
      w.mode_cmd.pin  = pin;
      w.mode_cmd.mode = pin_mode_e'(r[24:23]);
    end
    host_write(w);
    if (int'(pin) < NUM_PINS && is_gpio)
      {m_dir[pin], m_out[pin]} = {r[21], r[22]};
    else if (int'(pin) < NUM_PINS)
      m_mode[pin] = r[24:23];
  endtask

  initial
  begin
    lcg_state = 32'hff9c;
    wMEM_CLK = 1'b0;
    arst_n = 1'b0;
    cfg_req = 1'b0;
    cfg_word = 16'h8300;   // gpio write that drives pin 0 high
    {pwm, pin_in, alt2_out, alt3_out} = '0;
    {spi_flash, qspi, flash_io} = '0;
    {cycles, checks, mismatches} = '0;
    foreach (m_mode[i])
      m_mode[i] = 2'd0;
    m_dir = '0;
    m_out = '0;
    @(posedge wMEM_CLK);
    cfg_req <= 1'b1;   // request held through reset
    repeat (16)
    begin
      @(negedge wMEM_CLK);
      compare_value("pin_oe in reset", 32'(pin_oe), 32'd0);
      compare_value("ack in reset", 32'(cfg_ack), 32'd0);
    end
    @(posedge wMEM_CLK);
    arst_n <= 1'b1;
    repeat (RESET_STRETCH)
    begin
      @(negedge wMEM_CLK);
      compare_value("pin_oe in stretch", 32'(pin_oe), 32'd0);
      compare_value("ack in stretch", 32'(cfg_ack), 32'd0);
    end
    @(posedge wMEM_CLK);
    cfg_req <= 1'b0;
    for (int n = 0; n < 150; n++)
    begin
      random_write(1'b1, n % 29 == 7);   // gpio only so every pin stays in mode 0
      check_all();
    end
    for (int n = 0; n < 200; n++)
    begin
      @(posedge wMEM_CLK);
      drive_random_inputs();
      random_write(1'b0, n % 31 == 5);
      check_all();
    end
    repeat (100)
    begin
      @(posedge wMEM_CLK);
      drive_random_inputs();
      @(negedge wMEM_CLK);
      check_all();
    end
    $display("checks %0d, mismatches %0d", checks, mismatches);
    if (mismatches == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== pio_bridge_top.f ====
board_pins_pkg.sv
pio_cfg_pkg.sv
reset_stretch.sv
pio_cfg_regs.sv
header_pin_mux.sv
flash_pin_share.sv
pio_bridge_top.sv
pio_bridge_properties.sv
tb_pio_bridge_top.sv

// ==== Makefile ====
TOP = tb_pio_bridge_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f pio_bridge_top.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
